// File: source/sa_pkg.sv
package sa_pkg;

  // Default array size for the top level
  localparam int ROWS = 4;
  localparam int COLS = 4;

  // Signed element widths
  localparam int W_IN  = 8;
  localparam int W_ACC = 24;

  localparam int AXIL_DATA_W = 32;
  localparam int AXIL_ADDR_W = 8;

  // Register byte offsets
  localparam logic [AXIL_ADDR_W-1:0] REG_CTRL    = 8'h00;
  localparam logic [AXIL_ADDR_W-1:0] REG_BEATS   = 8'h04;
  localparam logic [AXIL_ADDR_W-1:0] REG_PACKETS = 8'h08;

  localparam logic [1:0] RESP_OKAY = 2'b00;

  // Bit 0 enable, bit 1 clamp
  typedef struct packed {
    logic clamp;
    logic enable;
  } ctrl_t;

  typedef struct packed {
    logic [AXIL_ADDR_W-1:0]   awaddr;
    logic                     awvalid;
    logic [AXIL_DATA_W-1:0]   wdata;
    logic [AXIL_DATA_W/8-1:0] wstrb;
    logic                     wvalid;
    logic                     bready;
    logic [AXIL_ADDR_W-1:0]   araddr;
    logic                     arvalid;
    logic                     rready;
  } axil_req_t;

  typedef struct packed {
    logic                   awready;
    logic                   wready;
    logic [1:0]             bresp;
    logic                   bvalid;
    logic                   arready;
    logic [AXIL_DATA_W-1:0] rdata;
    logic [1:0]             rresp;
    logic                   rvalid;
  } axil_rsp_t;

endpackage

// File: source/axil_csr.sv
module axil_csr (
  input  logic              clk,
  input  logic              rst,
  input  sa_pkg::axil_req_t axil,
  input  logic              beat_acc,
  input  logic              pkt_done,
  output sa_pkg::axil_rsp_t axil_rsp,
  output sa_pkg::ctrl_t     ctrl
);

  import sa_pkg::*;

  logic                   awready_q;
  logic                   bvalid_q;
  logic                   arready_q;
  logic                   rvalid_q;
  logic [AXIL_DATA_W-1:0] rdata_q;
  logic [AXIL_DATA_W-1:0] beats_q;
  logic [AXIL_DATA_W-1:0] pkts_q;
  ctrl_t                  ctrl_q;
  logic                   wr_fire;
  logic                   rd_fire;
  logic [AXIL_ADDR_W-1:0] wr_addr;
  logic [AXIL_ADDR_W-1:0] rd_addr;

  // Byte lane bits ignored
  assign wr_addr = {axil.awaddr[AXIL_ADDR_W-1:2], 2'b00};
  assign rd_addr = {axil.araddr[AXIL_ADDR_W-1:2], 2'b00};

  assign wr_fire = awready_q & axil.awvalid & axil.wvalid;
  assign rd_fire = arready_q & axil.arvalid;

  // Address and data taken together with one response outstanding
  always_ff @(posedge clk) begin
    if (rst) begin
      awready_q <= 1'b0;
      bvalid_q  <= 1'b0;
    end else begin
      awready_q <= ~awready_q & ~bvalid_q & axil.awvalid & axil.wvalid;
      if (wr_fire) begin
        bvalid_q <= 1'b1;
      end else if (axil.bready) begin
        bvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl_q <= '0;
    end else if (wr_fire && wr_addr == REG_CTRL && axil.wstrb[0]) begin
      ctrl_q <= ctrl_t'(axil.wdata[$bits(ctrl_t)-1:0]);
    end
  end

  // Read-only status counters
  always_ff @(posedge clk) begin
    if (rst) begin
      beats_q <= '0;
      pkts_q  <= '0;
    end else begin
      if (beat_acc) begin
        beats_q <= beats_q + 1'b1;
      end
      if (pkt_done) begin
        pkts_q <= pkts_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      arready_q <= 1'b0;
      rvalid_q  <= 1'b0;
    end else begin
      arready_q <= ~arready_q & ~rvalid_q & axil.arvalid;
      if (rd_fire) begin
        rvalid_q <= 1'b1;
      end else if (axil.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // Unmapped offsets read as zero
  always_ff @(posedge clk) begin
    if (rd_fire) begin
      case (rd_addr)
        REG_CTRL:    rdata_q <= AXIL_DATA_W'(ctrl_q);
        REG_BEATS:   rdata_q <= beats_q;
        REG_PACKETS: rdata_q <= pkts_q;
        default:     rdata_q <= '0;
      endcase
    end
  end

  always_comb begin
    axil_rsp         = '0;
    axil_rsp.awready = awready_q;
    axil_rsp.wready  = awready_q;
    axil_rsp.bresp   = RESP_OKAY;
    axil_rsp.bvalid  = bvalid_q;
    axil_rsp.arready = arready_q;
    axil_rsp.rdata   = rdata_q;
    axil_rsp.rresp   = RESP_OKAY;
    axil_rsp.rvalid  = rvalid_q;
  end

  assign ctrl = ctrl_q;

endmodule

// File: source/mac_grid.sv
module mac_grid #(
  parameter int ROWS = sa_pkg::ROWS,
  parameter int COLS = sa_pkg::COLS
) (
  input  logic                                         clk,
  input  logic                                         rst,
  input  sa_pkg::ctrl_t                                ctrl,
  input  logic [COLS-1:0][sa_pkg::W_IN-1:0]            k_data,
  input  logic                                         k_last,
  input  logic                                         k_valid,
  output logic                                         k_ready,
  input  logic [ROWS-1:0][sa_pkg::W_IN-1:0]            x_data,
  input  logic                                         x_last,
  input  logic                                         x_valid,
  output logic                                         x_ready,
  output logic                                         beat_acc,
  output logic [ROWS-1:0][COLS-1:0][sa_pkg::W_ACC-1:0] bank,
  output logic                                         bank_valid,
  input  logic                                         bank_ready
);

  import sa_pkg::*;

  logic join_valid;
  logic join_last;
  logic join_ready;
  logic fire;
  logic first_q;
  logic bank_valid_q;

  // Signed product widened to the accumulator
  function automatic logic signed [W_ACC-1:0] mac_term(
    input logic signed [W_IN-1:0] x,
    input logic signed [W_IN-1:0] k
  );
    logic signed [2*W_IN-1:0] p;
    p = x * k;
    return W_ACC'(p);
  endfunction

  // Each ready waits on the valid of the other stream
  assign join_valid = k_valid & x_valid;
  assign join_last  = k_last & x_last;

  // A last beat needs a free bank but middle beats may land on the handoff edge
  assign join_ready = ctrl.enable & (~bank_valid_q | (bank_ready & ~join_last));

  assign k_ready  = join_ready & x_valid;
  assign x_ready  = join_ready & k_valid;
  assign fire     = join_valid & join_ready;
  assign beat_acc = fire;

  always_ff @(posedge clk) begin
    if (rst) begin
      first_q      <= 1'b1;
      bank_valid_q <= 1'b0;
    end else begin
      if (fire) begin
        first_q <= join_last;
      end
      if (fire && join_last) begin
        bank_valid_q <= 1'b1;
      end else if (bank_ready) begin
        bank_valid_q <= 1'b0;
      end
    end
  end

  // Outer product of x and k added into every cell
  always_ff @(posedge clk) begin
    if (fire) begin
      for (int r = 0; r < ROWS; r++) begin
        for (int c = 0; c < COLS; c++) begin
          bank[r][c] <= (first_q ? '0 : bank[r][c]) + mac_term(x_data[r], k_data[c]);
        end
      end
    end
  end

  assign bank_valid = bank_valid_q;

endmodule

// File: source/column_drain.sv
module column_drain #(
  parameter int ROWS = sa_pkg::ROWS,
  parameter int COLS = sa_pkg::COLS
) (
  input  logic                                         clk,
  input  logic                                         rst,
  input  sa_pkg::ctrl_t                                ctrl,
  input  logic [ROWS-1:0][COLS-1:0][sa_pkg::W_ACC-1:0] bank,
  input  logic                                         bank_valid,
  output logic                                         bank_ready,
  input  logic [ROWS-1:0][sa_pkg::W_ACC-1:0]           a_data,
  input  logic                                         a_valid,
  output logic                                         a_ready,
  output logic [ROWS-1:0][sa_pkg::W_ACC-1:0]           y_data,
  output logic                                         y_last,
  output logic                                         y_valid,
  input  logic                                         y_ready,
  output logic                                         pkt_done
);

  import sa_pkg::*;

  localparam int CW = (COLS > 1) ? $clog2(COLS) : 1;

  logic [ROWS-1:0][COLS-1:0][W_ACC-1:0] snap;
  logic [ROWS-1:0][W_ACC-1:0]           sum;
  logic                                 busy_q;
  logic [CW-1:0]                        col_q;
  logic                                 last_col;
  logic                                 y_fire;

  assign bank_ready = ~busy_q;
  assign last_col   = (col_q == CW'(COLS - 1));

  // Output beat needs a column and a partial-sum beat
  assign y_valid  = busy_q & a_valid;
  assign a_ready  = busy_q & y_ready;
  assign y_last   = busy_q & last_col;
  assign y_fire   = y_valid & y_ready;
  assign pkt_done = y_fire & last_col;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= 1'b0;
      col_q  <= '0;
    end else if (!busy_q) begin
      if (bank_valid) begin
        busy_q <= 1'b1;
        col_q  <= '0;
      end
    end else if (y_fire) begin
      if (last_col) begin
        busy_q <= 1'b0;
      end else begin
        col_q <= col_q + 1'b1;
      end
    end
  end

  // Own copy so the grid can start the next packet
  always_ff @(posedge clk) begin
    if (bank_valid && bank_ready) begin
      snap <= bank;
    end
  end

  // Wrapping add, then optional clamp of negatives
  always_comb begin
    for (int r = 0; r < ROWS; r++) begin
      sum[r]    = snap[r][col_q] + a_data[r];
      y_data[r] = (ctrl.clamp && sum[r][W_ACC-1]) ? '0 : sum[r];
    end
  end

endmodule

// File: source/sa_top.sv
module sa_top #(
  parameter int ROWS = sa_pkg::ROWS,
  parameter int COLS = sa_pkg::COLS
) (
  input  logic                               clk,
  input  logic                               rst,

  // Configuration port
  input  sa_pkg::axil_req_t                  axil,
  output sa_pkg::axil_rsp_t                  axil_rsp,

  // Weights, one value per column
  input  logic [COLS-1:0][sa_pkg::W_IN-1:0]  k_data,
  input  logic                               k_last,
  input  logic                               k_valid,
  output logic                               k_ready,

  // Pixels, one value per row
  input  logic [ROWS-1:0][sa_pkg::W_IN-1:0]  x_data,
  input  logic                               x_last,
  input  logic                               x_valid,
  output logic                               x_ready,

  input  logic [ROWS-1:0][sa_pkg::W_ACC-1:0] a_data,
  input  logic                               a_valid,
  output logic                               a_ready,

  // One column per beat
  output logic [ROWS-1:0][sa_pkg::W_ACC-1:0] y_data,
  output logic                               y_last,
  output logic                               y_valid,
  input  logic                               y_ready
);

  import sa_pkg::*;

  ctrl_t                                ctrl;
  logic                                 beat_acc;
  logic                                 pkt_done;
  logic [ROWS-1:0][COLS-1:0][W_ACC-1:0] bank;
  logic                                 bank_valid;
  logic                                 bank_ready;

  axil_csr csr_i (
    .clk      (clk),
    .rst      (rst),
    .axil     (axil),
    .beat_acc (beat_acc),
    .pkt_done (pkt_done),
    .axil_rsp (axil_rsp),
    .ctrl     (ctrl)
  );

  mac_grid #(
    .ROWS (ROWS),
    .COLS (COLS)
  ) grid_i (
    .clk        (clk),
    .rst        (rst),
    .ctrl       (ctrl),
    .k_data     (k_data),
    .k_last     (k_last),
    .k_valid    (k_valid),
    .k_ready    (k_ready),
    .x_data     (x_data),
    .x_last     (x_last),
    .x_valid    (x_valid),
    .x_ready    (x_ready),
    .beat_acc   (beat_acc),
    .bank       (bank),
    .bank_valid (bank_valid),
    .bank_ready (bank_ready)
  );

  column_drain #(
    .ROWS (ROWS),
    .COLS (COLS)
  ) drain_i (
    .clk        (clk),
    .rst        (rst),
    .ctrl       (ctrl),
    .bank       (bank),
    .bank_valid (bank_valid),
    .bank_ready (bank_ready),
    .a_data     (a_data),
    .a_valid    (a_valid),
    .a_ready    (a_ready),
    .y_data     (y_data),
    .y_last     (y_last),
    .y_valid    (y_valid),
    .y_ready    (y_ready),
    .pkt_done   (pkt_done)
  );

endmodule

// File: test/sa_checker.sv
module sa_checker #(
  parameter int ROWS = sa_pkg::ROWS
) (
  input logic                               clk,
  input logic                               rst,
  input sa_pkg::axil_req_t                  axil,
  input sa_pkg::axil_rsp_t                  axil_rsp,
  input logic                               k_valid,
  input logic                               k_ready,
  input logic                               x_valid,
  input logic                               x_ready,
  input logic [ROWS-1:0][sa_pkg::W_ACC-1:0] y_data,
  input logic                               y_last,
  input logic                               y_valid,
  input logic                               y_ready
);

  import sa_pkg::*;

  typedef struct packed {
    logic                       last;
    logic [ROWS-1:0][W_ACC-1:0] data;
  } y_beat_t;

  y_beat_t                    y_exp_q[$];
  string                      y_name_q[$];
  logic [AXIL_DATA_W-1:0]     rd_exp_q[$];
  string                      rd_name_q[$];
  logic                       rst_q = 1'b1;
  logic                       stalled_q = 1'b0;
  logic [ROWS-1:0][W_ACC-1:0] stalled_data;
  int                         y_count = 0;
  int                         value_errs = 0;
  int                         proto_errs = 0;
  int                         missing_errs = 0;

  task automatic expect_y(input string name, input logic [ROWS-1:0][W_ACC-1:0] data,
                          input logic last);
    y_exp_q.push_back({last, data});
    y_name_q.push_back(name);
  endtask

  task automatic expect_rd(input string name, input logic [AXIL_DATA_W-1:0] value);
    rd_exp_q.push_back(value);
    rd_name_q.push_back(name);
  endtask

  task automatic report_missing();
    if (y_exp_q.size() > 0 || rd_exp_q.size() > 0) begin
      $display("%0d result beats and %0d register reads never arrived",
               y_exp_q.size(), rd_exp_q.size());
      missing_errs += y_exp_q.size() + rd_exp_q.size();
    end
  endtask

  always @(posedge clk) begin
    y_beat_t                exp_y;
    logic [AXIL_DATA_W-1:0] exp_rd;
    string                  name;
    // First edge after reset release shows the reset state
    if (rst_q && !rst) begin
      if (k_ready || x_ready || y_valid || axil_rsp.bvalid || axil_rsp.rvalid) begin
        $display("Handshake outputs were not idle when reset was released");
        proto_errs++;
      end
    end
    rst_q = rst;
    if (!rst) begin
      if ((k_valid && k_ready) !== (x_valid && x_ready)) begin
        $display("Weight and pixel beats did not transfer together");
        proto_errs++;
      end
      if (axil_rsp.awready !== axil_rsp.wready) begin
        $display("Write address ready and write data ready did not pulse together");
        proto_errs++;
      end
      if (stalled_q && (!y_valid || y_data !== stalled_data)) begin
        $display("Result beat was dropped or changed while y_ready was low");
        proto_errs++;
      end
      stalled_q    = y_valid && !y_ready;
      stalled_data = y_data;
      if (y_valid && y_ready) begin
        if (y_exp_q.size() == 0) begin
          $display("Result beat arrived with no expected value queued");
          proto_errs++;
        end else begin
          exp_y = y_exp_q.pop_front();
          name  = y_name_q.pop_front();
          if (y_data !== exp_y.data) begin
            $display("** Error %s y_data beat %0d: expected %h, actual %h",
                     name, y_count, exp_y.data, y_data);
            value_errs++;
          end
          if (y_last !== exp_y.last) begin
            $display("** Error %s y_last beat %0d: expected %b, actual %b",
                     name, y_count, exp_y.last, y_last);
            value_errs++;
          end
        end
        y_count++;
      end
      if (axil_rsp.rvalid && axil.rready) begin
        if (rd_exp_q.size() == 0) begin
          $display("Read response arrived with no read outstanding");
          proto_errs++;
        end else begin
          exp_rd = rd_exp_q.pop_front();
          name   = rd_name_q.pop_front();
          if (axil_rsp.rdata !== exp_rd || axil_rsp.rresp !== RESP_OKAY) begin
            $display("** Error %s read: expected %h resp 0, actual %h resp %0d",
                     name, exp_rd, axil_rsp.rdata, axil_rsp.rresp);
            value_errs++;
          end
        end
      end
      if (axil_rsp.bvalid && axil.bready && axil_rsp.bresp !== RESP_OKAY) begin
        $display("Write response was not OKAY");
        proto_errs++;
      end
    end
  end

endmodule

// File: test/sa_tb.sv
module sa_tb;

  import sa_pkg::*;

  localparam int R = 4;
  localparam int C = 4;
  localparam int N_TESTS = 4;

  typedef struct packed {
    logic [7:0] len;
    logic [7:0] npkts;
    logic       clamp;
    logic       neg;
    logic [7:0] dseed;
    logic [7:0] in_stall;
    logic [7:0] y_stall;
  } test_t;

  typedef struct packed {
    logic                   last;
    logic [C-1:0][W_IN-1:0] k;
    logic [R-1:0][W_IN-1:0] x;
  } in_beat_t;

  logic                    clk = 1'b0;
  logic                    rst = 1'b1;
  axil_req_t               axil = '0;
  axil_rsp_t               axil_rsp;
  logic [C-1:0][W_IN-1:0]  k_data = '0;
  logic                    k_last = 1'b0;
  logic                    k_valid = 1'b0;
  logic                    k_ready;
  logic [R-1:0][W_IN-1:0]  x_data = '0;
  logic                    x_last = 1'b0;
  logic                    x_valid = 1'b0;
  logic                    x_ready;
  logic [R-1:0][W_ACC-1:0] a_data = '0;
  logic                    a_valid = 1'b0;
  logic                    a_ready;
  logic [R-1:0][W_ACC-1:0] y_data;
  logic                    y_last;
  logic                    y_valid;
  logic                    y_ready = 1'b0;

  test_t                   tests[N_TESTS];
  string                   test_names[N_TESTS];
  in_beat_t                in_q[$];
  in_beat_t                stage_in[$];
  logic [R-1:0][W_ACC-1:0] a_q[$];
  logic [R-1:0][W_ACC-1:0] stage_a[$];
  logic [7:0]              in_stall = '0;
  logic [7:0]              y_stall = '0;
  logic [31:0]             in_gap = 32'heb03;
  logic [31:0]             y_gap;
  logic [31:0]             data_state;
  logic                    in_fire = 1'b0;
  logic                    a_fire = 1'b0;
  logic                    aw_fire = 1'b0;
  logic                    b_fire = 1'b0;
  logic                    ar_fire = 1'b0;
  logic                    r_fire = 1'b0;
  int                      cycles = 0;
  int                      cycle_limit = 0;
  int                      y_total = 0;
  int                      beats_total = 0;
  int                      pkts_total = 0;

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic test_t test_entry(input int len, input int npkts, input logic clamp,
                                       input logic neg, input int dseed, input int stall_in,
                                       input int stall_y);
    test_t t;
    t.len      = len;
    t.npkts    = npkts;
    t.clamp    = clamp;
    t.neg      = neg;
    t.dseed    = dseed;
    t.in_stall = stall_in;
    t.y_stall  = stall_y;
    return t;
  endfunction

  always #5 clk = ~clk;

  // Transfers seen at the clock edge for the drivers on the next falling edge
  always @(posedge clk) begin
    in_fire <= k_valid & k_ready;
    a_fire  <= a_valid & a_ready;
    aw_fire <= axil.awvalid & axil_rsp.awready;
    b_fire  <= axil_rsp.bvalid & axil.bready;
    ar_fire <= axil.arvalid & axil_rsp.arready;
    r_fire  <= axil_rsp.rvalid & axil.rready;
  end

  // Weight and pixel beats presented together and held until taken
  always @(negedge clk) begin
    in_beat_t nxt;
    if (in_fire) begin
      nxt = in_q.pop_front();
    end
    if (in_fire || !k_valid) begin
      in_gap = lcg_next(in_gap);
      if (in_q.size() > 0 && in_gap[15:8] >= in_stall) begin
        nxt     = in_q[0];
        k_data  = nxt.k;
        x_data  = nxt.x;
        k_last  = nxt.last;
        x_last  = nxt.last;
        k_valid = 1'b1;
        x_valid = 1'b1;
      end else begin
        k_valid = 1'b0;
        x_valid = 1'b0;
      end
    end
  end

  always @(negedge clk) begin
    if (a_fire) begin
      a_q.delete(0);
    end
    a_valid = (a_q.size() > 0);
    if (a_q.size() > 0) begin
      a_data = a_q[0];
    end
    y_gap   = lcg_next(y_gap);
    y_ready = (y_gap[15:8] >= y_stall);
  end

  task automatic print_counts();
    $display("Errors: %0d value, %0d protocol, %0d missing",
             chk_i.value_errs, chk_i.proto_errs, chk_i.missing_errs);
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("Run stopped at the limit of %0d cycles", cycle_limit);
      chk_i.report_missing();
      print_counts();
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  task automatic axil_write(input logic [AXIL_ADDR_W-1:0] addr,
                            input logic [AXIL_DATA_W-1:0] data);
    @(negedge clk);
    axil.awaddr  = addr;
    axil.wdata   = data;
    axil.awvalid = 1'b1;
    axil.wvalid  = 1'b1;
    do begin
      @(negedge clk);
    end while (!aw_fire);
    axil.awvalid = 1'b0;
    axil.wvalid  = 1'b0;
    do begin
      @(negedge clk);
    end while (!b_fire);
  endtask

  task automatic axil_read(input string name, input logic [AXIL_ADDR_W-1:0] addr,
                           input logic [AXIL_DATA_W-1:0] expected);
    chk_i.expect_rd(name, expected);
    @(negedge clk);
    axil.araddr  = addr;
    axil.arvalid = 1'b1;
    do begin
      @(negedge clk);
    end while (!ar_fire);
    axil.arvalid = 1'b0;
    do begin
      @(negedge clk);
    end while (!r_fire);
  endtask

  task automatic run_test(input int e);
    test_t                   t;
    logic signed [W_ACC-1:0] acc[R][C];
    logic signed [W_IN-1:0]  kv[C];
    logic signed [W_IN-1:0]  xv[R];
    logic [C-1:0][W_IN-1:0]  k_vec;
    logic [R-1:0][W_IN-1:0]  x_vec;
    logic signed [W_ACC-1:0] av;
    logic signed [W_ACC-1:0] s;
    logic [R-1:0][W_ACC-1:0] a_col;
    logic [R-1:0][W_ACC-1:0] y_col;
    logic [AXIL_DATA_W-1:0]  ctrl_word;
    t = tests[e];
    data_state = 32'heb03 + t.dseed;
    ctrl_word = '0;
    ctrl_word[1] = t.clamp;
    ctrl_word[0] = (e != 0);
    axil_write(REG_CTRL, ctrl_word);
    for (int p = 0; p < t.npkts; p++) begin
      for (int r = 0; r < R; r++) begin
        for (int c = 0; c < C; c++) begin
          acc[r][c] = '0;
        end
      end
      for (int b = 0; b < t.len; b++) begin
        for (int c = 0; c < C; c++) begin
          data_state = lcg_next(data_state);
          kv[c] = data_state[23:16];
          // Mostly negative weights
          if (t.neg) begin
            kv[c] = 8'sd8 - $signed({2'b00, data_state[21:16]});
          end
          k_vec[c] = kv[c];
        end
        for (int r = 0; r < R; r++) begin
          data_state = lcg_next(data_state);
          xv[r] = data_state[23:16];
          if (t.neg) begin
            xv[r] = {2'b00, data_state[21:16]};
          end
          x_vec[r] = xv[r];
        end
        stage_in.push_back({b == t.len - 1, k_vec, x_vec});
        for (int r = 0; r < R; r++) begin
          for (int c = 0; c < C; c++) begin
            acc[r][c] = acc[r][c] + xv[r] * kv[c];
          end
        end
      end
      for (int c = 0; c < C; c++) begin
        for (int r = 0; r < R; r++) begin
          data_state = lcg_next(data_state);
          if (t.neg) begin
            av = $signed(data_state[27:20]);
          end else begin
            av = $signed(data_state[31:16]);
          end
          a_col[r] = av;
          s = acc[r][c] + av;
          y_col[r] = (t.clamp && s < 0) ? '0 : s;
        end
        stage_a.push_back(a_col);
        chk_i.expect_y(test_names[e], y_col, c == C - 1);
        y_total++;
      end
    end
    @(posedge clk);
    while (stage_in.size() > 0) begin
      in_q.push_back(stage_in.pop_front());
    end
    while (stage_a.size() > 0) begin
      a_q.push_back(stage_a.pop_front());
    end
    in_stall = t.in_stall;
    y_stall  = t.y_stall;
    // First beat waits at the input until enable is set
    if (e == 0) begin
      repeat (8) @(negedge clk);
      axil_read("disabled", REG_BEATS, '0);
      ctrl_word[0] = 1'b1;
      axil_write(REG_CTRL, ctrl_word);
    end
    while (chk_i.y_count < y_total) begin
      @(negedge clk);
    end
  endtask

  sa_top #(
    .ROWS (R),
    .COLS (C)
  ) sa_top_i (
    .clk      (clk),
    .rst      (rst),
    .axil     (axil),
    .axil_rsp (axil_rsp),
    .k_data   (k_data),
    .k_last   (k_last),
    .k_valid  (k_valid),
    .k_ready  (k_ready),
    .x_data   (x_data),
    .x_last   (x_last),
    .x_valid  (x_valid),
    .x_ready  (x_ready),
    .a_data   (a_data),
    .a_valid  (a_valid),
    .a_ready  (a_ready),
    .y_data   (y_data),
    .y_last   (y_last),
    .y_valid  (y_valid),
    .y_ready  (y_ready)
  );

  sa_checker #(
    .ROWS (R)
  ) chk_i (
    .clk      (clk),
    .rst      (rst),
    .axil     (axil),
    .axil_rsp (axil_rsp),
    .k_valid  (k_valid),
    .k_ready  (k_ready),
    .x_valid  (x_valid),
    .x_ready  (x_ready),
    .y_data   (y_data),
    .y_last   (y_last),
    .y_valid  (y_valid),
    .y_ready  (y_ready)
  );

  initial begin
    test_t t;
    // len, packets, clamp, negative data, data seed, input gaps, y_ready gaps
    tests[0] = test_entry(3, 1, 1'b0, 1'b0, 1, 0, 0);
    tests[1] = test_entry(4, 1, 1'b1, 1'b1, 2, 0, 0);
    tests[2] = test_entry(4, 1, 1'b0, 1'b1, 2, 0, 0);
    tests[3] = test_entry(5, 5, 1'b0, 1'b0, 3, 80, 110);
    test_names[0] = "single";
    test_names[1] = "clamp_on";
    test_names[2] = "clamp_off";
    test_names[3] = "b2b_stall";
    for (int e = 0; e < N_TESTS; e++) begin
      t = tests[e];
      beats_total += t.len * t.npkts;
      pkts_total  += t.npkts;
    end
    cycle_limit = 50 + 20 * beats_total;
    y_gap = lcg_next(32'heb03);
    axil.wstrb  = '1;
    axil.bready = 1'b1;
    axil.rready = 1'b1;
    repeat (16) @(negedge clk);
    rst = 1'b0;
    axil_read("reset", REG_CTRL, '0);
    axil_read("reset", REG_BEATS, '0);
    axil_read("reset", REG_PACKETS, '0);
    for (int e = 0; e < N_TESTS; e++) begin
      run_test(e);
    end
    t = tests[N_TESTS-1];
    axil_read("counters", REG_BEATS, beats_total);
    axil_read("counters", REG_PACKETS, pkts_total);
    axil_write(REG_PACKETS, 32'hffff_ffff);
    axil_read("counters", REG_PACKETS, pkts_total);
    axil_read("counters", REG_CTRL, {30'b0, t.clamp, 1'b1});
    axil_read("unmapped", 8'h3c, '0);
    chk_i.report_missing();
    print_counts();
    if (chk_i.value_errs + chk_i.proto_errs + chk_i.missing_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: files.f
source/sa_pkg.sv
source/axil_csr.sv
source/mac_grid.sv
source/column_drain.sv
source/sa_top.sv
test/sa_checker.sv
test/sa_tb.sv

// File: Bender.yml
package:
  name: sa_accel

sources:
  - files:
      - source/sa_pkg.sv
      - source/axil_csr.sv
      - source/mac_grid.sv
      - source/column_drain.sv
      - source/sa_top.sv
  - target: test
    files:
      - test/sa_checker.sv
      - test/sa_tb.sv
